/* common/ladybird_pkg.sv */
package ladybird_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] pc_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      wstrb_t;
  typedef logic [2:0]      op_t;

  // decoded operations
  localparam op_t OP_NOP  = 3'd0;
  localparam op_t OP_LUI  = 3'd1;
  localparam op_t OP_ADDI = 3'd2;
  localparam op_t OP_ADD  = 3'd3;
  localparam op_t OP_SUB  = 3'd4;
  localparam op_t OP_LB   = 3'd5;
  localparam op_t OP_SB   = 3'd6;
  localparam op_t OP_JAL  = 3'd7;

  // rv32i major opcodes
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_RESULT
  } seq_state_t;

  // instruction encoders used by the boot image and the testbench
  function automatic word_t enc_lui(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic word_t enc_addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OPC_OPIMM};
  endfunction

  function automatic word_t enc_add(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  function automatic word_t enc_sub(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  function automatic word_t enc_lb(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OPC_LOAD};
  endfunction

  function automatic word_t enc_sb(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_jal(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic word_t enc_nop();
    return enc_addi(5'd0, 5'd0, 12'd0);
  endfunction

endpackage

/* design/ladybird_inst_ram.sv */
`timescale 1ns/1ps

module ladybird_inst_ram
  import ladybird_pkg::*;
#(
  parameter int IRAM_ADDR_W = 4
) (
  input  logic   clk,
  input  logic   nrst,
  input  logic   prog_req,
  input  pc_t    prog_addr,
  input  word_t  prog_wdata,
  input  wstrb_t prog_wstrb,
  input  logic   imem_req,
  input  pc_t    imem_addr,
  output logic   imem_gnt,
  output word_t  imem_rdata
);

  localparam int DEPTH = 2**IRAM_ADDR_W;

  word_t ram [DEPTH];

  logic [IRAM_ADDR_W-1:0] prog_idx;
  logic [IRAM_ADDR_W-1:0] fetch_idx;

  assign prog_idx  = prog_addr[IRAM_ADDR_W+1:2];  // word index
  assign fetch_idx = imem_addr[IRAM_ADDR_W+1:2];

  // the boot image is rewritten on every reset
  always_ff @(posedge clk) begin
    if (!nrst) begin
      for (int i = 0; i < DEPTH; i++) begin
        ram[i] <= enc_nop();
      end
      ram[0] <= enc_lui(5'd1, 20'hE0000);
      ram[1] <= enc_lb(5'd3, 5'd0, 12'h002);
      ram[2] <= enc_sb(5'd3, 5'd0, 12'h005);
      ram[3] <= enc_jal(5'd0, -21'sd12);  // back to the start
    end else if (prog_req) begin
      for (int i = 0; i < 4; i++) begin
        if (prog_wstrb[i]) ram[prog_idx][8*i +: 8] <= prog_wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      imem_gnt <= 1'b0;
    end else begin
      imem_gnt <= imem_req;
    end
  end

  always_ff @(posedge clk) begin
    if (imem_req) imem_rdata <= ram[fetch_idx];
  end

  // the program may only be loaded while the core is stopped
  a_no_load_during_fetch: assert property (
    @(posedge clk) disable iff (!nrst) !(prog_req && imem_req)
  );

endmodule

/* core/ladybird_decode.sv */
`timescale 1ns/1ps

module ladybird_decode
  import ladybird_pkg::*;
#(
  parameter pc_t RESET_PC = '0
) (
  input  logic     clk,
  input  logic     nrst,
  input  logic     run,
  output logic     imem_req,
  output pc_t      imem_addr,
  input  logic     imem_gnt,
  input  word_t    imem_rdata,
  output logic     exec_start,
  output op_t      op,
  output reg_idx_t rd,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output word_t    imm,
  output pc_t      pc,
  input  pc_t      next_pc,
  input  logic     wb_done
);

  seq_state_t state;

  op_t      dec_op;
  word_t    dec_imm;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = imem_rdata[6:0];
  assign funct3 = imem_rdata[14:12];
  assign funct7 = imem_rdata[31:25];

  always_comb begin
    dec_op  = OP_NOP;
    dec_imm = {{20{imem_rdata[31]}}, imem_rdata[31:20]};  // I-type by default
    case (opcode)
      OPC_LUI: begin
        dec_op  = OP_LUI;
        dec_imm = {imem_rdata[31:12], 12'b0};
      end
      OPC_OPIMM: if (funct3 == 3'b000) dec_op = OP_ADDI;
      OPC_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) dec_op = OP_ADD;
        if (funct3 == 3'b000 && funct7 == 7'b0100000) dec_op = OP_SUB;
      end
      OPC_LOAD: if (funct3 == 3'b000) dec_op = OP_LB;
      OPC_STORE: begin
        if (funct3 == 3'b000) dec_op = OP_SB;
        dec_imm = {{20{imem_rdata[31]}}, imem_rdata[31:25], imem_rdata[11:7]};
      end
      OPC_JAL: begin
        dec_op  = OP_JAL;
        dec_imm = {{11{imem_rdata[31]}}, imem_rdata[31], imem_rdata[19:12],
                   imem_rdata[20], imem_rdata[30:21], 1'b0};
      end
      default: dec_op = OP_NOP;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state <= S_IDLE;
      pc    <= RESET_PC;
    end else begin
      case (state)
        S_IDLE:   if (run) state <= S_FETCH;
        S_FETCH:  state <= S_DECODE;
        S_DECODE: if (imem_gnt) state <= S_EXEC;
        S_EXEC:   state <= (op == OP_LB) ? S_MEM : S_RESULT;
        S_MEM:    state <= S_RESULT;  // load data on its way back
        S_RESULT: begin
          if (wb_done) begin
            pc    <= next_pc;
            state <= run ? S_FETCH : S_IDLE;
          end
        end
        default:  state <= S_IDLE;
      endcase
    end
  end

  // decoded fields stay put until the next fetch returns
  always_ff @(posedge clk) begin
    if (state == S_DECODE && imem_gnt) begin
      op  <= dec_op;
      rd  <= (dec_op == OP_NOP) ? 5'd0 : imem_rdata[11:7];
      rs1 <= imem_rdata[19:15];
      rs2 <= imem_rdata[24:20];
      imm <= dec_imm;
    end
  end

  assign imem_req   = (state == S_FETCH);
  assign imem_addr  = pc;
  assign exec_start = (state == S_EXEC);

endmodule

/* core/ladybird_execute.sv */
`timescale 1ns/1ps

module ladybird_execute
  import ladybird_pkg::*;
#(
  parameter int DRAM_ADDR_W = 6
) (
  input  logic       clk,
  input  logic       nrst,
  input  logic       exec_start,
  input  op_t        op,
  input  reg_idx_t   rd,
  input  word_t      imm,
  input  pc_t        pc,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  output logic       dmem_req,
  output pc_t        dmem_addr,
  output word_t      dmem_wdata,
  output wstrb_t     dmem_wstrb,
  output logic       res_valid,
  output op_t        res_op,
  output reg_idx_t   res_rd,
  output word_t      res_value,
  output logic [1:0] res_byte_sel,
  output pc_t        res_pc,
  output pc_t        next_pc
);

  word_t sum;
  word_t diff;
  word_t addi_val;
  word_t link;
  pc_t   eff_addr;
  word_t alu_out;

  assign sum      = rs1_data + rs2_data;
  assign diff     = rs1_data - rs2_data;
  assign addi_val = rs1_data + imm;
  assign link     = pc + 32'd4;
  assign eff_addr = rs1_data + imm;  // shared by LB and SB

  always_comb begin
    case (op)
      OP_LUI:  alu_out = imm;
      OP_ADDI: alu_out = addi_val;
      OP_ADD:  alu_out = sum;
      OP_SUB:  alu_out = diff;
      OP_JAL:  alu_out = link;
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      res_valid <= 1'b0;
      dmem_req  <= 1'b0;
    end else begin
      res_valid <= exec_start;
      dmem_req  <= exec_start && (op == OP_LB || op == OP_SB);
    end
  end

  always_ff @(posedge clk) begin
    if (exec_start) begin
      res_op       <= op;
      res_rd       <= (op == OP_SB) ? 5'd0 : rd;
      res_value    <= alu_out;
      res_byte_sel <= eff_addr[1:0];
      res_pc       <= pc;
      next_pc      <= (op == OP_JAL) ? pc + imm : link;
      dmem_addr    <= eff_addr;
      dmem_wdata   <= {4{rs2_data[7:0]}};  // byte copied to every lane
      dmem_wstrb   <= (op == OP_SB) ? wstrb_t'(4'b0001 << eff_addr[1:0]) : 4'b0000;
    end
  end

  // programs must stay inside the data RAM
  a_dmem_in_range: assert property (
    @(posedge clk) disable iff (!nrst)
      dmem_req |-> (dmem_addr >> (DRAM_ADDR_W + 2)) == '0
  );

endmodule

/* core/ladybird_result.sv */
`timescale 1ns/1ps

module ladybird_result
  import ladybird_pkg::*;
(
  input  logic       clk,
  input  logic       nrst,
  input  logic       res_valid,
  input  op_t        res_op,
  input  reg_idx_t   res_rd,
  input  word_t      res_value,
  input  logic [1:0] res_byte_sel,
  input  pc_t        res_pc,
  input  logic       dmem_gnt,
  input  word_t      dmem_rdata,
  input  reg_idx_t   rs1,
  input  reg_idx_t   rs2,
  output word_t      rs1_data,
  output word_t      rs2_data,
  output logic       wb_done,
  output logic       retire_valid,
  output pc_t        retire_pc,
  output reg_idx_t   retire_rd,
  output word_t      retire_value
);

  word_t rf [32];

  logic       load_pending;
  logic       wr_en;
  logic [7:0] load_byte;
  word_t      load_value;
  word_t      wr_data;

  assign rs1_data = (rs1 == 5'd0) ? '0 : rf[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : rf[rs2];

  assign load_byte  = dmem_rdata[8*res_byte_sel +: 8];
  assign load_value = {{24{load_byte[7]}}, load_byte};  // sign extend

  assign wr_en   = (res_valid && res_op != OP_LB) || dmem_gnt;
  assign wr_data = dmem_gnt ? load_value : res_value;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (wr_en && res_rd != 5'd0) begin
      rf[res_rd] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      load_pending <= 1'b0;
      retire_valid <= 1'b0;
    end else begin
      if (res_valid && res_op == OP_LB) load_pending <= 1'b1;
      else if (dmem_gnt) load_pending <= 1'b0;
      retire_valid <= wr_en;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      retire_pc    <= res_pc;
      retire_rd    <= res_rd;
      retire_value <= (res_rd == 5'd0) ? '0 : wr_data;  // x0 always reports zero
    end
  end

  assign wb_done = retire_valid;

  // read data only comes back for a load issued by execute
  a_gnt_needs_load: assert property (
    @(posedge clk) disable iff (!nrst) dmem_gnt |-> load_pending
  );

endmodule

/* design/ladybird_data_ram.sv */
`timescale 1ns/1ps

module ladybird_data_ram
  import ladybird_pkg::*;
#(
  parameter int DRAM_ADDR_W = 6
) (
  input  logic   clk,
  input  logic   nrst,
  input  logic   dmem_req,
  input  pc_t    dmem_addr,
  input  word_t  dmem_wdata,
  input  wstrb_t dmem_wstrb,
  output logic   dmem_gnt,
  output word_t  dmem_rdata
);

  localparam int DEPTH = 2**DRAM_ADDR_W;

  word_t mem [DEPTH];

  logic [DRAM_ADDR_W-1:0] idx;
  logic                   is_read;

  assign idx     = dmem_addr[DRAM_ADDR_W+1:2];
  assign is_read = dmem_req && (dmem_wstrb == 4'b0000);  // no strobe means a read

  always_ff @(posedge clk) begin
    if (!nrst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      dmem_gnt <= 1'b0;
    end else begin
      dmem_gnt <= is_read;
      if (dmem_req) begin
        for (int i = 0; i < 4; i++) begin
          if (dmem_wstrb[i]) mem[idx][8*i +: 8] <= dmem_wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (is_read) dmem_rdata <= mem[idx];
  end

endmodule

/* design/ladybird_top.sv */
`timescale 1ns/1ps

module ladybird_top
  import ladybird_pkg::*;
#(
  parameter int  IRAM_ADDR_W = 4,
  parameter int  DRAM_ADDR_W = 6,
  parameter pc_t RESET_PC    = '0
) (
  input  logic     clk,
  input  logic     nrst,
  input  logic     run,
  input  logic     prog_req,
  input  pc_t      prog_addr,
  input  word_t    prog_wdata,
  input  wstrb_t   prog_wstrb,
  output logic     retire_valid,
  output pc_t      retire_pc,
  output reg_idx_t retire_rd,
  output word_t    retire_value
);

  logic       imem_req;
  pc_t        imem_addr;
  logic       imem_gnt;
  word_t      imem_rdata;
  logic       exec_start;
  op_t        op;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      imm;
  pc_t        pc;
  pc_t        next_pc;
  logic       wb_done;
  word_t      rs1_data;
  word_t      rs2_data;
  logic       dmem_req;
  pc_t        dmem_addr;
  word_t      dmem_wdata;
  wstrb_t     dmem_wstrb;
  logic       dmem_gnt;
  word_t      dmem_rdata;
  logic       res_valid;
  op_t        res_op;
  reg_idx_t   res_rd;
  word_t      res_value;
  logic [1:0] res_byte_sel;
  pc_t        res_pc;

  ladybird_inst_ram #(.IRAM_ADDR_W(IRAM_ADDR_W)) u_inst_ram (
    .clk, .nrst, .prog_req, .prog_addr, .prog_wdata, .prog_wstrb,
    .imem_req, .imem_addr, .imem_gnt, .imem_rdata
  );

  ladybird_decode #(.RESET_PC(RESET_PC)) u_decode (
    .clk, .nrst, .run, .imem_req, .imem_addr, .imem_gnt, .imem_rdata,
    .exec_start, .op, .rd, .rs1, .rs2, .imm, .pc, .next_pc, .wb_done
  );

  ladybird_execute #(.DRAM_ADDR_W(DRAM_ADDR_W)) u_execute (
    .clk, .nrst, .exec_start, .op, .rd, .imm, .pc, .rs1_data, .rs2_data,
    .dmem_req, .dmem_addr, .dmem_wdata, .dmem_wstrb,
    .res_valid, .res_op, .res_rd, .res_value, .res_byte_sel, .res_pc, .next_pc
  );

  ladybird_result u_result (
    .clk, .nrst, .res_valid, .res_op, .res_rd, .res_value, .res_byte_sel, .res_pc,
    .dmem_gnt, .dmem_rdata, .rs1, .rs2, .rs1_data, .rs2_data, .wb_done,
    .retire_valid, .retire_pc, .retire_rd, .retire_value
  );

  ladybird_data_ram #(.DRAM_ADDR_W(DRAM_ADDR_W)) u_data_ram (
    .clk, .nrst, .dmem_req, .dmem_addr, .dmem_wdata, .dmem_wstrb,
    .dmem_gnt, .dmem_rdata
  );

endmodule

/* tb/tb_ladybird.sv */
`timescale 1ns/1ps

module tb_ladybird
  import ladybird_pkg::*;
();

  localparam int  IRAM_ADDR_W = 4;
  localparam int  DRAM_ADDR_W = 6;
  localparam pc_t RESET_PC    = 32'h0000_0000;
  localparam int  IRAM_WORDS  = 2**IRAM_ADDR_W;
  localparam int  DRAM_BYTES  = 4 * 2**DRAM_ADDR_W;
  // program words plus retirements per test, 6 cycles each, plus 20 cycles of setup per test
  localparam int  TIMEOUT_CYCLES = (10 + 22 + 30 + 14 + 10 + 28) * 6 + 6 * 20;

  logic     clk;
  logic     nrst;
  logic     run;
  logic     prog_req;
  pc_t      prog_addr;
  word_t    prog_wdata;
  wstrb_t   prog_wstrb;
  logic     retire_valid;
  pc_t      retire_pc;
  reg_idx_t retire_rd;
  word_t    retire_value;

  // program image, with the fields the reference model works from
  word_t    img   [IRAM_WORDS];
  op_t      m_op  [IRAM_WORDS];
  reg_idx_t m_rd  [IRAM_WORDS];
  reg_idx_t m_rs1 [IRAM_WORDS];
  reg_idx_t m_rs2 [IRAM_WORDS];
  word_t    m_imm [IRAM_WORDS];
  int       n_instr;

  word_t       xreg  [32];
  logic [7:0]  dbyte [DRAM_BYTES];
  pc_t         m_pc;
  int          cycles;

  ladybird_top #(
    .IRAM_ADDR_W(IRAM_ADDR_W),
    .DRAM_ADDR_W(DRAM_ADDR_W),
    .RESET_PC(RESET_PC)
  ) i_dut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) abort_run($sformatf("timeout after %0d cycles", cycles));
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_pc(input string name, input pc_t exp, input pc_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s pc expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic check_rd(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s rd expected x%0d actual x%0d", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s value expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  function automatic void clear_program();
    n_instr = 0;
    for (int i = 0; i < IRAM_WORDS; i++) begin
      img[i]  = enc_nop();
      m_op[i] = OP_NOP;
      m_rd[i] = 5'd0;
    end
  endfunction

  // the encoders keep only the immediate bits their format holds
  function automatic void put(op_t o, reg_idx_t d, reg_idx_t s1, reg_idx_t s2, word_t i);
    case (o)
      OP_LUI:  img[n_instr] = enc_lui(d, i[31:12]);
      OP_ADDI: img[n_instr] = enc_addi(d, s1, i[11:0]);
      OP_ADD:  img[n_instr] = enc_add(d, s1, s2);
      OP_SUB:  img[n_instr] = enc_sub(d, s1, s2);
      OP_LB:   img[n_instr] = enc_lb(d, s1, i[11:0]);
      OP_SB:   img[n_instr] = enc_sb(s2, s1, i[11:0]);
      OP_JAL:  img[n_instr] = enc_jal(d, i[20:0]);
      default: img[n_instr] = enc_nop();
    endcase
    m_op[n_instr]  = o;
    m_rd[n_instr]  = d;
    m_rs1[n_instr] = s1;
    m_rs2[n_instr] = s2;
    m_imm[n_instr] = i;
    n_instr++;
  endfunction

  function automatic void put_raw(word_t w);
    img[n_instr]  = w;
    m_op[n_instr] = OP_NOP;  // outside the supported subset
    m_rd[n_instr] = 5'd0;
    n_instr++;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    nrst <= 1'b0;
    run  <= 1'b0;
    repeat (8) @(posedge clk);
    nrst <= 1'b1;
    for (int i = 0; i < 32; i++) xreg[i] = '0;
    for (int i = 0; i < DRAM_BYTES; i++) dbyte[i] = '0;
    m_pc = RESET_PC;
  endtask

  // each word goes in as two halves through the byte strobes
  // lanes outside the strobe carry inverted data that must not land
  task automatic load_program();
    for (int i = 0; i < n_instr; i++) begin
      @(posedge clk);
      prog_req   <= 1'b1;
      prog_addr  <= RESET_PC + pc_t'(4 * i);
      prog_wdata <= {~img[i][31:16], img[i][15:0]};
      prog_wstrb <= 4'b0011;
      @(posedge clk);
      prog_wdata <= {img[i][31:16], ~img[i][15:0]};
      prog_wstrb <= 4'b1100;
    end
    @(posedge clk);
    prog_req   <= 1'b0;
    prog_wstrb <= 4'b0000;
  endtask

  task automatic model_step(output pc_t e_pc, output reg_idx_t e_rd, output word_t e_val);
    int    k;
    word_t a;
    word_t v;
    pc_t   npc;
    k    = int'(m_pc[IRAM_ADDR_W+1:2]);
    a    = xreg[m_rs1[k]] + m_imm[k];
    v    = '0;
    npc  = m_pc + 32'd4;
    e_rd = m_rd[k];
    case (m_op[k])
      OP_LUI:  v = m_imm[k];
      OP_ADDI: v = a;
      OP_ADD:  v = xreg[m_rs1[k]] + xreg[m_rs2[k]];
      OP_SUB:  v = xreg[m_rs1[k]] - xreg[m_rs2[k]];
      OP_LB:   v = {{24{dbyte[a[DRAM_ADDR_W+1:0]][7]}}, dbyte[a[DRAM_ADDR_W+1:0]]};
      OP_SB: begin
        dbyte[a[DRAM_ADDR_W+1:0]] = xreg[m_rs2[k]][7:0];
        e_rd = 5'd0;
      end
      OP_JAL: begin
        v   = m_pc + 32'd4;  // link
        npc = m_pc + m_imm[k];
      end
      default: e_rd = 5'd0;
    endcase
    if (e_rd == 5'd0) v = '0;
    else xreg[e_rd] = v;
    e_pc  = m_pc;
    e_val = v;
    m_pc  = npc;
  endtask

  task automatic run_checked(input string name, input int n);
    pc_t      e_pc;
    reg_idx_t e_rd;
    word_t    e_val;
    int       got;
    got = 0;
    @(posedge clk);
    run <= 1'b1;
    while (got < n) begin
      @(posedge clk);
      if (retire_valid) begin
        model_step(e_pc, e_rd, e_val);
        check_pc(name, e_pc, retire_pc);
        check_rd(name, e_rd, retire_rd);
        check_word(name, e_val, retire_value);
        got++;
        if (got == n - 1) run <= 1'b0;  // core stops after the next retirement
      end
    end
    repeat (8) begin
      @(posedge clk);
      if (retire_valid) abort_run($sformatf("%s kept retiring after run went low", name));
    end
  endtask

  task automatic test_reset();
    apply_reset();
    repeat (10) begin
      @(posedge clk);
      if (retire_valid !== 1'b0) abort_run("retire_valid rose after reset with run low");
    end
    // the model follows the boot image that reset put in place
    clear_program();
    put(OP_LUI, 1, 0, 0, 32'hE000_0000);
    put(OP_LB, 3, 0, 0, 2);
    put(OP_SB, 0, 0, 3, 5);
    put(OP_JAL, 0, 0, 0, -12);
    run_checked("reset", 6);
  endtask

  task automatic test_alu();
    apply_reset();
    clear_program();
    put(OP_LUI, 1, 0, 0, 32'h1234_5000);
    put(OP_ADDI, 2, 1, 0, 'h678);
    put(OP_ADDI, 3, 0, 0, -5);
    put(OP_ADD, 4, 2, 3, 0);
    put(OP_SUB, 5, 3, 2, 0);
    put(OP_SUB, 6, 0, 1, 0);
    put(OP_ADDI, 0, 1, 0, 1);   // x0 stays zero
    put(OP_ADD, 0, 1, 2, 0);
    put(OP_ADD, 7, 0, 3, 0);
    put(OP_ADDI, 1, 1, 0, -2048);
    put(OP_ADD, 2, 2, 2, 0);
    load_program();
    run_checked("alu", 11);
  endtask

  task automatic test_byte_mem();
    apply_reset();
    clear_program();
    put(OP_ADDI, 1, 0, 0, 'h7f);
    put(OP_ADDI, 2, 0, 0, -128);
    put(OP_ADDI, 3, 0, 0, 'h5a);
    put(OP_ADDI, 4, 0, 0, -1);
    for (int i = 0; i < 4; i++) put(OP_SB, 0, 0, reg_idx_t'(i + 1), 16 + i);
    for (int i = 0; i < 5; i++) put(OP_LB, reg_idx_t'(i + 5), 0, 0, 16 + i);
    put(OP_ADDI, 10, 0, 0, 32);
    put(OP_LB, 11, 10, 0, 3);
    load_program();
    run_checked("byte_mem", 15);
  endtask

  task automatic test_jumps();
    apply_reset();
    clear_program();
    put(OP_ADDI, 1, 0, 0, 5);
    put(OP_JAL, 2, 0, 0, 12);
    put(OP_ADDI, 3, 1, 0, 1);
    put(OP_ADD, 6, 3, 2, 0);
    put(OP_ADDI, 4, 0, 0, 7);
    put(OP_JAL, 5, 0, 0, -12);
    load_program();
    run_checked("jumps", 8);
  endtask

  task automatic test_unknown();
    apply_reset();
    clear_program();
    put(OP_ADDI, 1, 0, 0, 3);
    put_raw({12'h123, 5'd1, 3'b000, 5'd4, 7'b1111111});
    put_raw({12'h001, 5'd1, 3'b001, 5'd6, 7'b0010011});  // slli
    put(OP_ADDI, 2, 1, 0, 4);
    put(OP_ADD, 3, 4, 6, 0);
    load_program();
    run_checked("unknown", 5);
  endtask

  task automatic test_random();
    reg_idx_t    d;
    reg_idx_t    a;
    reg_idx_t    b;
    logic [11:0] r12;
    apply_reset();
    clear_program();
    for (int i = 0; i < 14; i++) begin
      d   = reg_idx_t'($urandom_range(7, 1));
      a   = reg_idx_t'($urandom_range(7, 1));
      b   = reg_idx_t'($urandom_range(7, 1));
      r12 = 12'($urandom);
      if ($urandom_range(1, 0) == 1) put(OP_ADD, d, a, b, 0);
      else put(OP_ADDI, d, a, 0, {{20{r12[11]}}, r12});
    end
    load_program();
    run_checked("random", 14);
  endtask

  initial begin
    clk        = 1'b0;
    nrst       = 1'b0;
    run        = 1'b0;
    prog_req   = 1'b0;
    prog_addr  = '0;
    prog_wdata = '0;
    prog_wstrb = '0;
    cycles     = 0;
    void'($urandom(33));
    test_reset();
    test_alu();
    test_byte_mem();
    test_jumps();
    test_unknown();
    test_random();
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* vlog.f */
common/ladybird_pkg.sv
design/ladybird_inst_ram.sv
core/ladybird_decode.sv
core/ladybird_execute.sv
core/ladybird_result.sv
design/ladybird_data_ram.sv
design/ladybird_top.sv
tb/tb_ladybird.sv

/* Bender.yml */
package:
  name: ladybird

sources:
  - common/ladybird_pkg.sv
  - design/ladybird_inst_ram.sv
  - core/ladybird_decode.sv
  - core/ladybird_execute.sv
  - core/ladybird_result.sv
  - design/ladybird_data_ram.sv
  - design/ladybird_top.sv
  - target: test
    files:
      - tb/tb_ladybird.sv
